// ==== spi_burst_ctrl.sv ====
`timescale 1ns/100ps

module spi_burst_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      start,
  input  logic [spi_pkg::LEN_W-1:0] len,
  output logic                      busy,
  output logic                      cs_n,
  input  logic                      tx_empty,
  output logic                      tx_pop,
  input  logic [7:0]                tx_head,
  input  logic                      rx_full,
  output logic                      rx_push,
  output logic [7:0]                rx_byte,
  output logic                      xfer_start,
  output logic [7:0]                xfer_tx,
  input  logic                      xfer_done,
  input  logic [7:0]                xfer_rx
);
  import spi_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT_BYTE,
    ST_STORE,
    ST_FINISH
  } state_t;

  state_t           state;
  logic [LEN_W-1:0] remaining;
  logic             launch;

  // a byte goes out only once there is one queued and the transceiver is free
  assign launch     = (state == ST_FETCH) && !tx_empty && xfer_done;
  assign tx_pop     = launch;
  assign xfer_start = launch;
  assign xfer_tx    = tx_head;

  // a full receive FIFO keeps us in store, which stalls the whole burst
  assign rx_push = (state == ST_STORE) && !rx_full;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state     <= ST_IDLE;
      remaining <= '0;
      busy      <= 1'b0;
      cs_n      <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start && len != '0) begin
            remaining <= len;
            busy      <= 1'b1;
            cs_n      <= 1'b0;
            state     <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (launch) begin
            state <= ST_WAIT_BYTE;
          end
        end
        ST_WAIT_BYTE: begin
          // done drops the cycle after the launch, so a high level here is the finished byte
          if (xfer_done) begin
            state <= ST_STORE;
          end
        end
        ST_STORE: begin
          if (rx_push) begin
            remaining <= remaining - 1'b1;
            if (remaining == LEN_W'(1)) begin
              cs_n  <= 1'b1;
              state <= ST_FINISH;
            end else begin
              state <= ST_FETCH;
            end
          end
        end
        ST_FINISH: begin
          busy  <= 1'b0;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == ST_WAIT_BYTE && xfer_done) begin
      rx_byte <= xfer_rx;
    end
  end

endmodule

// ==== spi_byte_fifo.sv ====
`timescale 1ns/100ps

module spi_byte_fifo (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       wr,
  input  logic [7:0] wdata,
  output logic       full,
  input  logic       rd,
  output logic [7:0] rdata,
  output logic       empty
);
  import spi_pkg::*;

  logic [7:0]         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_CW-1:0] count;
  logic               do_wr;
  logic               do_rd;

  assign full  = (count == FIFO_CW'(FIFO_DEPTH));
  assign empty = (count == '0);

  // requests that would overflow or underflow are dropped here
  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  // the head entry is always visible and a read just moves on to the next one
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== spi_host.sv ====
`timescale 1ns/100ps

module spi_host (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  spi_pkg::spi_conf_t        conf,
  input  logic                      start,
  input  logic [spi_pkg::LEN_W-1:0] len,
  input  logic                      tx_wr,
  input  logic [7:0]                tx_data,
  output logic                      tx_full,
  input  logic                      rx_rd,
  output logic [7:0]                rx_data,
  output logic                      rx_empty,
  output logic                      busy,
  output spi_pkg::spi_pins_t        pins,
  input  logic                      miso
);

  logic       tx_empty;
  logic       tx_pop;
  logic [7:0] tx_head;
  logic       rx_full;
  logic       rx_push;
  logic [7:0] rx_byte;
  logic       xfer_start;
  logic [7:0] xfer_tx;
  logic       xfer_done;
  logic [7:0] xfer_rx;
  logic       sclk;
  logic       mosi;
  logic       cs_n;

  assign pins.sclk = sclk;
  assign pins.mosi = mosi;
  assign pins.cs_n = cs_n;

  // host writes, controller pops
  spi_byte_fifo i_tx_fifo (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .wr    (tx_wr),
    .wdata (tx_data),
    .full  (tx_full),
    .rd    (tx_pop),
    .rdata (tx_head),
    .empty (tx_empty)
  );

  // controller pushes, host reads
  spi_byte_fifo i_rx_fifo (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .wr    (rx_push),
    .wdata (rx_byte),
    .full  (rx_full),
    .rd    (rx_rd),
    .rdata (rx_data),
    .empty (rx_empty)
  );

  spi_burst_ctrl i_burst_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start      (start),
    .len        (len),
    .busy       (busy),
    .cs_n       (cs_n),
    .tx_empty   (tx_empty),
    .tx_pop     (tx_pop),
    .tx_head    (tx_head),
    .rx_full    (rx_full),
    .rx_push    (rx_push),
    .rx_byte    (rx_byte),
    .xfer_start (xfer_start),
    .xfer_tx    (xfer_tx),
    .xfer_done  (xfer_done),
    .xfer_rx    (xfer_rx)
  );

  spi_xcvr i_xcvr (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .conf  (conf),
    .start (xfer_start),
    .tx    (xfer_tx),
    .rx    (xfer_rx),
    .done  (xfer_done),
    .miso  (miso),
    .mosi  (mosi),
    .sclk  (sclk)
  );

endmodule

// ==== spi_pkg.sv ====
package spi_pkg;

  // SPI mode and bit rate stay fixed for the length of a burst
  typedef struct packed {
    logic hispeed;
    logic cpol;
    logic cpha;
  } spi_conf_t;

  // pins driven by the master towards the slave
  typedef struct packed {
    logic sclk;
    logic mosi;
    logic cs_n;
  } spi_pins_t;

  localparam int CLOCK_FREQ = 50_000_000;
  localparam int HI_SPEED   = 8_000_000;
  localparam int LO_SPEED   = 500_000;

  // each divider tick ends an SCLK half period of terminal count plus one cycles
  localparam int HI_DIV = CLOCK_FREQ / HI_SPEED;
  localparam int LO_DIV = CLOCK_FREQ / LO_SPEED;

  // the slow rate has the larger count and sets the counter width
  localparam int DIV_W = $clog2(LO_DIV + 1);

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

  // a burst moves 1 to FIFO_DEPTH bytes
  localparam int LEN_W = 5;

endpackage

// ==== spi_slave_model.sv ====
`timescale 1ns/100ps

module spi_slave_model (
  input  spi_pkg::spi_conf_t conf,
  input  spi_pkg::spi_pins_t pins,
  output logic               miso
);

  logic [7:0] reply_q[$];
  logic [7:0] mosi_q[$];
  logic [7:0] cur_byte = 8'h00;
  logic [7:0] in_byte  = 8'h00;
  logic       loaded   = 1'b0;
  int         bit_cnt  = 0;
  logic       sclk;
  logic       cs_n;

  assign sclk = pins.sclk;
  assign cs_n = pins.cs_n;

  initial begin
    miso = 1'b0;
  end

  task automatic push_reply(input logic [7:0] b);
    reply_q.push_back(b);
  endtask

  task automatic pop_mosi(output logic [7:0] b);
    b = mosi_q.pop_front();
  endtask

  function automatic int mosi_count();
    return mosi_q.size();
  endfunction

  task automatic load_reply();
    if (reply_q.size() > 0) begin
      cur_byte = reply_q.pop_front();
    end else begin
      cur_byte = 8'h00;
    end
    loaded = 1'b1;
  endtask

  always begin
    @(negedge cs_n);
    bit_cnt = 0;
    // with cpha clear the first bit has to be on MISO before the first edge
    if (!conf.cpha) begin
      if (!loaded) begin
        load_reply();
      end
      miso = cur_byte[7];
    end
    while (cs_n == 1'b0) begin
      @(sclk or cs_n);
      if (cs_n == 1'b0) begin
        // a leading edge samples in mode 0 and 2, a trailing edge in mode 1 and 3
        if ((sclk != conf.cpol) != conf.cpha) begin
          in_byte = {in_byte[6:0], pins.mosi};
          bit_cnt++;
          if (bit_cnt == 8) begin
            mosi_q.push_back(in_byte);
            bit_cnt = 0;
            loaded  = 1'b0;
          end
        end else begin
          // phase 0 preloads the next reply here, but only once one has been queued
          if (bit_cnt == 0 && !loaded && (conf.cpha || reply_q.size() > 0)) begin
            load_reply();
          end
          miso = cur_byte[7 - bit_cnt];
        end
      end
    end
  end

endmodule

// ==== spi_xcvr.sv ====
`timescale 1ns/100ps

module spi_xcvr (
  input  logic               clk_i,
  input  logic               rst_i,
  input  spi_pkg::spi_conf_t conf,
  input  logic               start,
  input  logic [7:0]         tx,
  output logic [7:0]         rx,
  output logic               done,
  input  logic               miso,
  output logic               mosi,
  output logic               sclk
);
  import spi_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_LEAD,
    ST_TRAIL
  } state_t;

  state_t           state;
  state_t           state_next;
  logic [8:0]       buffer;
  logic [8:0]       buffer_next;
  logic [2:0]       bits;
  logic [2:0]       bits_next;
  logic             phase;
  logic             phase_next;
  logic [DIV_W-1:0] div_cnt;
  logic [DIV_W-1:0] div_max;
  logic             tick;

  assign div_max = conf.hispeed ? DIV_W'(HI_DIV) : DIV_W'(LO_DIV);
  assign tick    = (div_cnt == div_max);

  // phase counts SCLK away from its idle level, so SCLK idles at cpol in every mode
  assign sclk = conf.cpol ^ phase;
  assign done = (state == ST_IDLE);
  assign mosi = buffer[8];

  // with cpha set the last sample lands in bit 0, otherwise it is shifted up once more
  assign rx = conf.cpha ? buffer[7:0] : buffer[8:1];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      div_cnt <= '0;
    end else if (state == ST_IDLE || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= ST_IDLE;
      bits  <= '0;
      phase <= 1'b0;
    end else begin
      state <= state_next;
      bits  <= bits_next;
      phase <= phase_next;
    end
  end

  always_ff @(posedge clk_i) begin
    buffer <= buffer_next;
  end

  always_comb begin
    state_next  = state;
    buffer_next = buffer;
    bits_next   = bits;
    phase_next  = phase;
    case (state)
      ST_IDLE: begin
        phase_next = 1'b0;
        if (start) begin
          // for cpha clear the first bit has to sit on MOSI before the first edge
          buffer_next = conf.cpha ? {1'b0, tx} : {tx, 1'b0};
          bits_next   = 3'd7;
          state_next  = ST_START;
        end
      end
      ST_START: begin
        state_next = ST_LEAD;
      end
      ST_LEAD: begin
        if (tick) begin
          if (conf.cpha) begin
            buffer_next = {buffer[7:0], 1'b0};
          end else begin
            buffer_next[0] = miso;
          end
          phase_next = 1'b1;
          state_next = ST_TRAIL;
        end
      end
      ST_TRAIL: begin
        if (tick) begin
          if (conf.cpha) begin
            buffer_next[0] = miso;
          end else begin
            buffer_next = {buffer[7:0], 1'b0};
          end
          phase_next = 1'b0;
          bits_next  = bits - 1'b1;
          state_next = (bits == 3'd0) ? ST_IDLE : ST_LEAD;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

endmodule

// ==== tb.f ====
spi_pkg.sv
spi_byte_fifo.sv
spi_xcvr.sv
spi_burst_ctrl.sv
spi_host.sv
spi_slave_model.sv
tb_spi_host.sv

// ==== tb_spi_host.sv ====
`timescale 1ns/100ps

module tb_spi_host;
  import spi_pkg::*;

  localparam int WAIT_LIMIT = 5000;

  logic             clk_i;
  logic             rst_i;
  spi_conf_t        conf;
  logic             start;
  logic [LEN_W-1:0] len;
  logic             tx_wr;
  logic [7:0]       tx_data;
  logic             tx_full;
  logic             rx_rd;
  logic [7:0]       rx_data;
  logic             rx_empty;
  logic             busy;
  spi_pins_t        pins;
  logic             miso;
  logic [7:0]       tx_model[$];
  logic [7:0]       rx_model[$];
  int               errors;
  int               errors_before;
  int               tests_run;
  int               tests_failed;
  int               burst_len;
  int               wait_count;
  int unsigned      seed;
  int unsigned      first_rand;
  logic             held;

  spi_host i_spi_host (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .conf     (conf),
    .start    (start),
    .len      (len),
    .tx_wr    (tx_wr),
    .tx_data  (tx_data),
    .tx_full  (tx_full),
    .rx_rd    (rx_rd),
    .rx_data  (rx_data),
    .rx_empty (rx_empty),
    .busy     (busy),
    .pins     (pins),
    .miso     (miso)
  );

  spi_slave_model i_slave (
    .conf (conf),
    .pins (pins),
    .miso (miso)
  );

  always #5 clk_i = ~clk_i;

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    errors++;
    $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // tasks start and return just after a falling edge
  task automatic write_tx(input logic [7:0] b);
    if (tx_model.size() < FIFO_DEPTH) begin
      tx_model.push_back(b);
    end
    tx_wr   = 1'b1;
    tx_data = b;
    @(negedge clk_i);
    tx_wr = 1'b0;
  endtask

  // every byte written gets a random reply queued in the slave
  task automatic queue_bytes(input int n);
    logic [7:0] r;
    for (int i = 0; i < n; i++) begin
      write_tx(8'($urandom));
      r = 8'($urandom);
      i_slave.push_reply(r);
      rx_model.push_back(r);
    end
  endtask

  task automatic start_burst(input int n);
    start = 1'b1;
    len   = LEN_W'(n);
    @(negedge clk_i);
    start = 1'b0;
  endtask

  task automatic read_rx(input int n);
    logic [7:0] exp;
    int         k;
    for (int i = 0; i < n; i++) begin
      k = 0;
      while (rx_empty && k < WAIT_LIMIT) begin
        @(negedge clk_i);
        k++;
      end
      if (rx_empty) begin
        errors++;
        $display("timeout waiting for receive data");
        return;
      end
      exp = rx_model.pop_front();
      if (rx_data !== exp) value_error("rx_data", exp, rx_data);
      rx_rd = 1'b1;
      @(negedge clk_i);
      rx_rd = 1'b0;
    end
  endtask

  task automatic finish_burst(input int n_sent, input int n_read);
    logic [7:0] b;
    logic [7:0] exp;
    int         k;
    k = 0;
    while (busy && k < WAIT_LIMIT) begin
      @(negedge clk_i);
      k++;
    end
    if (busy) begin
      errors++;
      $display("timeout waiting for busy to fall");
    end
    if (pins.cs_n !== 1'b1) value_error("cs_n", 1, pins.cs_n);
    if (i_slave.mosi_count() != n_sent) begin
      value_error("slave byte count", n_sent, i_slave.mosi_count());
    end
    while (i_slave.mosi_count() > 0) begin
      i_slave.pop_mosi(b);
      if (tx_model.size() == 0) begin
        errors++;
        $display("slave received a byte that was never written");
      end else begin
        exp = tx_model.pop_front();
        if (b !== exp) value_error("mosi byte", exp, b);
      end
    end
    read_rx(n_read);
  endtask

  // counts the falling edges that see SCLK away from idle during one half period
  task automatic measure_half(input int expected);
    int n;
    int half;
    n    = 0;
    half = 0;
    while (pins.sclk === conf.cpol && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    while (pins.sclk !== conf.cpol && half < WAIT_LIMIT) begin
      @(negedge clk_i);
      half++;
    end
    if (n == WAIT_LIMIT || half == WAIT_LIMIT) begin
      errors++;
      $display("timeout measuring the SCLK half period");
    end else if (half != expected) begin
      value_error("sclk half period", expected, half);
    end
  endtask

  initial begin
    seed       = 32'hd93e_28fb;
    first_rand = $urandom(seed);
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    conf       = 3'b110;
    start      = 1'b0;
    len        = '0;
    tx_wr      = 1'b0;
    tx_data    = '0;
    rx_rd      = 1'b0;
    errors        = 0;
    errors_before = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    if (busy !== 1'b0) value_error("busy", 0, busy);
    if (pins.cs_n !== 1'b1) value_error("cs_n", 1, pins.cs_n);
    if (rx_empty !== 1'b1) value_error("rx_empty", 1, rx_empty);
    if (tx_full !== 1'b0) value_error("tx_full", 0, tx_full);
    if (pins.sclk !== conf.cpol) value_error("sclk", conf.cpol, pins.sclk);
    end_test("reset state");

    for (int m = 0; m < 4; m++) begin
      conf = {1'b1, 2'(m)};
      @(negedge clk_i);
      repeat (3) begin
        burst_len = 1 + $urandom % 16;
        queue_bytes(burst_len);
        start_burst(burst_len);
        finish_burst(burst_len, burst_len);
      end
    end
    end_test("random bursts in all modes");

    queue_bytes(2);
    start_burst(2);
    measure_half(HI_DIV + 1);
    finish_burst(2, 2);
    conf.hispeed = 1'b0;
    @(negedge clk_i);
    queue_bytes(1);
    start_burst(1);
    measure_half(LO_DIV + 1);
    finish_burst(1, 1);
    conf.hispeed = 1'b1;
    @(negedge clk_i);
    end_test("sclk half period");

    queue_bytes(FIFO_DEPTH);
    if (tx_full !== 1'b1) value_error("tx_full", 1, tx_full);
    write_tx(8'($urandom));
    start_burst(FIFO_DEPTH);
    finish_burst(FIFO_DEPTH, FIFO_DEPTH);
    queue_bytes(3);
    start_burst(3);
    finish_burst(3, 3);
    end_test("transmit FIFO full");

    // a burst longer than the queued data stalls after the first byte
    conf = 3'b111;
    @(negedge clk_i);
    queue_bytes(1);
    start_burst(3);
    wait_count = 0;
    while (rx_empty && wait_count < WAIT_LIMIT) begin
      @(negedge clk_i);
      wait_count++;
    end
    held = 1'b1;
    repeat (50) begin
      @(negedge clk_i);
      if (pins.cs_n !== 1'b0 || pins.sclk !== conf.cpol || busy !== 1'b1) held = 1'b0;
    end
    if (rx_empty || !held) begin
      errors++;
      $display("burst did not wait with cs_n low and SCLK idle for transmit data");
    end
    queue_bytes(2);
    finish_burst(3, 3);

    // receive FIFO already full, so the second burst stops after one byte
    queue_bytes(FIFO_DEPTH);
    start_burst(FIFO_DEPTH);
    finish_burst(FIFO_DEPTH, 0);
    queue_bytes(FIFO_DEPTH);
    start_burst(FIFO_DEPTH);
    held = 1'b1;
    repeat (400) begin
      @(negedge clk_i);
      if (busy !== 1'b1 || pins.cs_n !== 1'b0) held = 1'b0;
    end
    if (!held) begin
      errors++;
      $display("burst ended while the receive FIFO was full");
    end
    if (i_slave.mosi_count() != 1) value_error("slave byte count", 1, i_slave.mosi_count());
    read_rx(FIFO_DEPTH);
    finish_burst(FIFO_DEPTH, FIFO_DEPTH);
    end_test("back-pressure");

    queue_bytes(4);
    start_burst(4);
    repeat (10) @(negedge clk_i);
    start_burst(5);
    finish_burst(4, 4);
    held = 1'b1;
    repeat (20) begin
      @(negedge clk_i);
      if (busy !== 1'b0 || pins.cs_n !== 1'b1) held = 1'b0;
    end
    if (!held) begin
      errors++;
      $display("a start pulse while busy launched another burst");
    end
    end_test("start while busy");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
